//--- bench/mem_pipe_tb.sv
`default_nettype none
`timescale 1ns/10ps

module mem_pipe_tb;

    localparam int MAX_ENTRIES = 64;
    localparam int MAX_LINES   = 256;
    localparam int IDLE_CYCLES = 4;
    localparam int LATENCY     = 3;
    localparam int DRAIN_LIMIT = 16;

    typedef struct packed {
        int          test;
        int          due;
        logic [31:0] rdata;
        logic        mis;
    } expect_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    memsys_pkg::mem_req_t req;
    memsys_pkg::mem_rsp_t rsp;

    memsys_pkg::mem_req_t req_tab [MAX_ENTRIES];
    int                   test_tab [MAX_ENTRIES];
    logic [31:0]          exp_rdata_tab [MAX_ENTRIES];
    logic                 exp_mis_tab [MAX_ENTRIES];
    int                   n_entries;
    expect_t              exp_q [$];

    int cyc;
    int cur_errs;
    int total_errs;
    int tests_passed;
    int tests_failed;
    int waited;
    bit trace_ok;

    always #5 clk = ~clk;

    mem_pipe_top dut (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .rsp_o   (rsp)
    );

    function automatic string test_name(input int t);
        case (t)
            1: return "word store and load";
            2: return "byte and half-word merge";
            3: return "sign and zero extension";
            4: return "misaligned accesses";
            5: return "back-to-back burst";
            default: return "unnamed";
        endcase
    endfunction

    // ##############################
    // trace reading
    // ##############################

    task automatic load_trace(output bit ok);
        int          fd;
        int          n_lines;
        int          cnt;
        string       line;
        int          test_v;
        int          op_v;
        int          size_v;
        int          uns_v;
        int          mis_v;
        logic [31:0] addr_v;
        logic [31:0] wdata_v;
        logic [31:0] rdata_v;
        ok        = 1'b0;
        n_entries = 0;
        n_lines   = 0;
        fd = $fopen("bench/mem_pipe_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file bench/mem_pipe_trace.txt");
            return;
        end
        ok = 1'b1;
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            n_lines++;
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%d %d %d %d %h %h %h %d", test_v, op_v, size_v, uns_v,
                          addr_v, wdata_v, rdata_v, mis_v);
            if (cnt != 8 || n_entries >= MAX_ENTRIES) begin
                $display("trace line %0d is malformed or the trace is too long", n_lines);
                ok = 1'b0;
                break;
            end
            req_tab[n_entries].valid       = 1'b1;
            req_tab[n_entries].wr          = op_v[0];
            req_tab[n_entries].size        = memsys_pkg::memop_size_e'(size_v[1:0]);
            req_tab[n_entries].is_unsigned = uns_v[0];
            req_tab[n_entries].addr        = addr_v;
            req_tab[n_entries].wdata       = wdata_v;
            test_tab[n_entries]            = test_v;
            exp_rdata_tab[n_entries]       = rdata_v;
            exp_mis_tab[n_entries]         = mis_v[0];
            n_entries++;
        end
        $fclose(fd);
        if (n_entries == 0) begin
            $display("the trace holds no accesses");
            ok = 1'b0;
        end
    endtask

    // ##############################
    // checking
    // ##############################

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("Fail %s expected 0x%08h got 0x%08h", name, exp, got);
            cur_errs++;
        end
    endtask

    task automatic finish_test(input int t);
        if (cur_errs == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", t, test_name(t));
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", t, test_name(t), cur_errs);
        end
        total_errs += cur_errs;
        cur_errs = 0;
    endtask

    task automatic check_response();
        expect_t e;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            check_value("rsp_o.valid", 32'd1, 32'(rsp.valid));
            check_value("rsp_o.misaligned", 32'(e.mis), 32'(rsp.misaligned));
            check_value("rsp_o.rdata", e.rdata, rsp.rdata);
            if (exp_q.size() == 0 || exp_q[0].test != e.test) begin
                finish_test(e.test);
            end
        end else begin
            // nothing is due in this cycle, so the response stays idle.
            check_value("rsp_o.valid", 32'd0, 32'(rsp.valid));
        end
    endtask

    task automatic run_cycle(input bit drive, input int idx);
        expect_t e;
        @(posedge clk);
        if (drive) begin
            req     <= req_tab[idx];
            e.test  = test_tab[idx];
            e.due   = cyc + LATENCY;
            e.rdata = exp_rdata_tab[idx];
            e.mis   = exp_mis_tab[idx];
            exp_q.push_back(e);
        end else begin
            req <= '0;
        end
        @(negedge clk);
        check_response();
        cyc++;
    endtask

    initial begin
        rst_n        = 1'b0;
        req          = '0;
        cyc          = 0;
        cur_errs     = 0;
        total_errs   = 0;
        tests_passed = 0;
        tests_failed = 0;
        waited       = 0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("Test failed");
        end else begin
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            for (int i = 0; i < IDLE_CYCLES; i++) begin
                run_cycle(1'b0, 0);
            end
            for (int k = 0; k < n_entries; k++) begin
                run_cycle(1'b1, k);
            end
            while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
                run_cycle(1'b0, 0);
                waited++;
            end
            if (exp_q.size() > 0) begin
                $display("timeout with %0d responses still outstanding", exp_q.size());
                $display("Test failed");
            end else begin
                $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
                if (tests_failed == 0 && total_errs == 0 && cur_errs == 0) begin
                    $display("Test completed successfully");
                end else begin
                    $display("Test failed");
                end
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mem_pipe_trace.txt
# test op(0 load, 1 store) size(0 byte, 1 half, 2 word) unsigned addr wdata exp_rdata exp_mis
# addr, wdata and exp_rdata are hex; the other columns are decimal.
1 1 2 0 00000100 deadbeef 00000000 0
1 0 2 0 00000100 00000000 deadbeef 0
1 1 2 0 00000104 12345678 00000000 0
1 1 2 0 00000100 0badf00d 00000000 0
1 0 2 0 00000104 00000000 12345678 0
1 0 2 0 00000100 00000000 0badf00d 0
2 1 2 0 00000200 11223344 00000000 0
2 1 0 0 00000201 ffffffaa 00000000 0
2 1 0 0 00000203 000000bb 00000000 0
2 0 2 0 00000200 00000000 bb22aa44 0
2 1 1 0 00000202 1234c0de 00000000 0
2 0 2 0 00000200 00000000 c0deaa44 0
3 1 2 0 00000300 80f17f85 00000000 0
3 0 0 0 00000300 00000000 ffffff85 0
3 0 0 1 00000300 00000000 00000085 0
3 0 0 0 00000301 00000000 0000007f 0
3 0 1 0 00000302 00000000 ffff80f1 0
3 0 1 1 00000302 00000000 000080f1 0
4 1 2 0 00000380 01234567 00000000 0
4 1 2 0 00000381 ffffffff 00000000 1
4 0 2 0 00000382 00000000 00000000 1
4 0 1 0 00000381 00000000 00000000 1
4 0 2 0 00000380 00000000 01234567 0
4 0 0 0 00000383 00000000 00000001 0
5 1 2 0 000003c0 00000001 00000000 0
5 1 2 0 000003fc feedface 00000000 0
5 0 2 0 000003c0 00000000 00000001 0
5 0 2 0 000003fc 00000000 feedface 0
5 0 1 1 000003fe 00000000 0000feed 0

//--- build.f
+incdir+logic
logic/memsys_pkg.sv
logic/memop_align.sv
logic/byte_memory.sv
logic/load_extend.sv
logic/mem_pipe_top.sv
bench/mem_pipe_tb.sv

//--- logic/byte_memory.sv
`default_nettype none
`timescale 1ns/10ps

`include "memsys_macros.svh"

module byte_memory (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire memsys_pkg::mem_acc_t acc_i,
    output memsys_pkg::mem_rd_t       rd_o
);

    localparam int unsigned BE_W  = `MEMSYS_XLEN / 8;
    localparam int unsigned WORDS = `MEMSYS_MEM_BYTES / BE_W;
    localparam int unsigned IDX_W = $clog2(WORDS);

    // in each little-endian row byte lane 0 holds the lowest address of the word.
    logic [`MEMSYS_XLEN-1:0] mem_q [WORDS];

    logic [IDX_W-1:0] row_idx;
    logic             wr_en;
    logic             rd_en;

    assign row_idx = acc_i.word_addr[IDX_W+1:2];
    assign wr_en   = acc_i.valid && acc_i.wr;
    assign rd_en   = acc_i.valid && !acc_i.wr;

    // ##############################
    // array write
    // ##############################

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (acc_i.byte_en[b]) begin
                    mem_q[row_idx][8*b +: 8] <= acc_i.lane_wdata[8*b +: 8];
                end
            end
        end
    end

    // ##############################
    // registered read
    // ##############################

    // only a load refreshes the read word.
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rd_o.word <= mem_q[row_idx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_o.valid <= 1'b0;
        end else begin
            rd_o.valid <= acc_i.valid;
        end
        rd_o.wr          <= acc_i.wr;
        rd_o.size        <= acc_i.size;
        rd_o.is_unsigned <= acc_i.is_unsigned;
        rd_o.misaligned  <= acc_i.misaligned;
        rd_o.byte_off    <= acc_i.byte_off;
    end

    // upper address bits are dropped by the row index, so they must be zero.
    addr_in_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        acc_i.valid |-> (acc_i.word_addr < (`MEMSYS_ADDR_W-2)'(WORDS)));

endmodule

`default_nettype wire

//--- logic/load_extend.sv
`default_nettype none
`timescale 1ns/10ps

`include "memsys_macros.svh"

module load_extend (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire memsys_pkg::mem_rd_t rd_i,
    output memsys_pkg::mem_rsp_t     rsp_o
);

    localparam int unsigned XLEN = `MEMSYS_XLEN;

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] extended;

    // bring the addressed byte or half-word down to bit 0.
    assign shifted = rd_i.word >> (8 * rd_i.byte_off);

    always_comb begin
        case (rd_i.size)
            memsys_pkg::SIZE_BYTE: begin
                if (rd_i.is_unsigned) begin
                    extended = XLEN'(shifted[7:0]);
                end else begin
                    extended = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
                end
            end
            memsys_pkg::SIZE_HALF: begin
                if (rd_i.is_unsigned) begin
                    extended = XLEN'(shifted[15:0]);
                end else begin
                    extended = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
                end
            end
            memsys_pkg::SIZE_WORD: begin
                extended = shifted;
            end
            default: begin
                extended = '0;
            end
        endcase
    end

    // ##############################
    // response register
    // ##############################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_o.valid <= 1'b0;
        end else begin
            rsp_o.valid <= rd_i.valid;
        end
        rsp_o.misaligned <= rd_i.misaligned;
        // stores and faulting loads return nothing from memory.
        rsp_o.rdata      <= (rd_i.wr || rd_i.misaligned) ? '0 : extended;
    end

    // only half and word accesses can arrive flagged as misaligned.
    byte_never_misaligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rd_i.valid && rd_i.misaligned) |-> rd_i.size != memsys_pkg::SIZE_BYTE);

endmodule

`default_nettype wire

//--- logic/mem_pipe_top.sv
`default_nettype none
`timescale 1ns/10ps

module mem_pipe_top (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire memsys_pkg::mem_req_t req_i,
    output memsys_pkg::mem_rsp_t      rsp_o
);

    // ##############################
    // stage to stage links
    // ##############################

    memsys_pkg::mem_acc_t acc;
    memsys_pkg::mem_rd_t  rd;

    // stage 1 checks alignment and places the store data on its byte lanes.
    memop_align u_memop_align (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .acc_o   (acc)
    );

    // stage 2 holds the array and either writes it or reads one word per edge.
    byte_memory u_byte_memory (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .acc_i   (acc),
        .rd_o    (rd)
    );

    // stage 3 selects the loaded bytes and extends them into the response.
    load_extend u_load_extend (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rd_i    (rd),
        .rsp_o   (rsp_o)
    );

endmodule

`default_nettype wire

//--- logic/memop_align.sv
`default_nettype none
`timescale 1ns/10ps

`include "memsys_macros.svh"

module memop_align (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire memsys_pkg::mem_req_t req_i,
    output memsys_pkg::mem_acc_t      acc_o
);

    localparam int unsigned BE_W  = `MEMSYS_XLEN / 8;
    localparam int unsigned OFF_W = $clog2(BE_W);

    logic [OFF_W-1:0]        byte_off;
    logic                    misaligned;
    logic [BE_W-1:0]         size_mask;
    logic [`MEMSYS_XLEN-1:0] lane_wdata;

    assign byte_off = req_i.addr[OFF_W-1:0];

    // ##############################
    // alignment and lane mask
    // ##############################

    always_comb begin
        misaligned = 1'b0;
        size_mask  = '0;
        case (req_i.size)
            memsys_pkg::SIZE_BYTE: begin
                size_mask = BE_W'(1) << byte_off;
            end
            memsys_pkg::SIZE_HALF: begin
                misaligned = req_i.addr[0];
                size_mask  = BE_W'(3) << byte_off;
            end
            memsys_pkg::SIZE_WORD: begin
                misaligned = |req_i.addr[1:0];
                size_mask  = '1;
            end
            default: begin
                misaligned = 1'b0;
                size_mask  = '0;
            end
        endcase
    end

    // the low byte of the store data moves to the lane picked by the offset.
    assign lane_wdata = req_i.wdata << (8 * byte_off);

    // ##############################
    // stage register
    // ##############################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_o.valid <= 1'b0;
        end else begin
            acc_o.valid <= req_i.valid;
        end
        acc_o.wr          <= req_i.wr;
        acc_o.size        <= req_i.size;
        acc_o.is_unsigned <= req_i.is_unsigned;
        acc_o.misaligned  <= misaligned;
        acc_o.byte_off    <= byte_off;
        // loads and misaligned stores must never touch the array.
        acc_o.byte_en     <= (req_i.wr && !misaligned) ? size_mask : '0;
        acc_o.word_addr   <= req_i.addr[`MEMSYS_ADDR_W-1:2];
        acc_o.lane_wdata  <= lane_wdata;
    end

    // the core only issues the three defined access sizes.
    size_legal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i.valid |-> req_i.size inside {memsys_pkg::SIZE_BYTE, memsys_pkg::SIZE_HALF,
                                           memsys_pkg::SIZE_WORD});

endmodule

`default_nettype wire

//--- logic/memsys_macros.svh
`ifndef MEMSYS_MACROS_SVH
`define MEMSYS_MACROS_SVH

// ##############################
// data path widths
// ##############################

// width of one data word and of the memory rows.
`define MEMSYS_XLEN 32

// width of the byte address carried by every request.
`define MEMSYS_ADDR_W 32

// ##############################
// memory geometry
// ##############################

// size of the data memory in bytes; only the low address bits select a row.
`define MEMSYS_MEM_BYTES 1024

`endif

//--- logic/memsys_pkg.sv
`default_nettype none

`include "memsys_macros.svh"

package memsys_pkg;

    // access size of a load or store; 2'b11 is not used.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } memop_size_e;

    // request as presented by the core.
    typedef struct packed {
        logic                      valid;
        logic                      wr;
        memop_size_e               size;
        logic                      is_unsigned;
        logic [`MEMSYS_ADDR_W-1:0] addr;
        logic [`MEMSYS_XLEN-1:0]   wdata;
    } mem_req_t;

    // access leaving stage 1 with its store data already on the byte lanes.
    typedef struct packed {
        logic                                valid;
        logic                                wr;
        memop_size_e                         size;
        logic                                is_unsigned;
        logic                                misaligned;
        logic [$clog2(`MEMSYS_XLEN/8)-1:0]   byte_off;
        logic [`MEMSYS_XLEN/8-1:0]           byte_en;
        logic [`MEMSYS_ADDR_W-1:2]           word_addr;
        logic [`MEMSYS_XLEN-1:0]             lane_wdata;
    } mem_acc_t;

    // raw word read in stage 2 together with what stage 3 needs to extract the load.
    typedef struct packed {
        logic                                valid;
        logic                                wr;
        memop_size_e                         size;
        logic                                is_unsigned;
        logic                                misaligned;
        logic [$clog2(`MEMSYS_XLEN/8)-1:0]   byte_off;
        logic [`MEMSYS_XLEN-1:0]             word;
    } mem_rd_t;

    typedef struct packed {
        logic                    valid;
        logic                    misaligned;
        logic [`MEMSYS_XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module mem_pipe_tb -f build.f -o mem_pipe_sim

./obj_dir/mem_pipe_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
